/* common/retire_pkg.sv */
`default_nettype none

`include "rob_config.svh"

package retire_pkg;

    import uop_pkg::*;

    typedef struct packed {
        logic             valid;
        robn_t            robn;
        logic             branch_taken;  // don't care for non-branches
        logic [`XLEN-1:0] target_addr;
    } fu_result_t;

    typedef struct packed {
        logic       valid;
        rob_entry_t entry;
    } commit_t;

    typedef commit_t [`ROB_N-1:0] commit_bundle_t;

    // physical register given back at retirement
    typedef struct packed {
        logic valid;
        prn_t prn;
    } freed_t;

    typedef struct packed {
        logic       write;
        logic [1:0] addr;
        logic [7:0] wdata;
    } cfg_req_t;

    localparam logic [1:0] REG_ALERT    = 2'd0;  // writable almost-full threshold
    localparam logic [1:0] REG_RETIRED  = 2'd1;  // read-only retired count
    localparam logic [1:0] REG_SQUASHES = 2'd2;  // read-only squash count

endpackage

`default_nettype wire

/* common/rob_config.svh */
`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

// dispatch and commit width
`define ROB_N 2

// reorder buffer depth, and the widths of its index and occupancy
`define ROB_SZ 16
`define ROB_PTR_W 4
`define ROB_CNT_W 5

// functional unit completion ports
`define FU_CNT 3

// register file indices
`define ARN_W 5
`define PRN_W 6

// address and data width
`define XLEN 32

`endif

/* common/uop_pkg.sv */
`default_nettype none

`include "rob_config.svh"

package uop_pkg;

    typedef logic [`ROB_PTR_W-1:0] robn_t;
    typedef logic [`ARN_W-1:0]     arn_t;
    typedef logic [`PRN_W-1:0]     prn_t;

    typedef struct packed {
        logic              executed;       // result is back
        logic              success;        // cleared on a mispredict
        logic              is_store;
        logic              cond_branch;
        logic              uncond_branch;
        logic              predict_taken;
        logic [`XLEN-1:0]  predict_target;
        logic              resolve_taken;
        logic [`XLEN-1:0]  resolve_target;
        logic              has_dest;
        arn_t              dest_arn;
        prn_t              dest_prn;
        logic [`XLEN-1:0]  pc;
    } rob_entry_t;

    // lanes are in program order, lane 0 oldest
    typedef struct packed {
        logic [`ROB_N-1:0]       valid;
        rob_entry_t [`ROB_N-1:0] entry;
    } dispatch_t;

endpackage

`default_nettype wire

/* design/arch_map.sv */
`default_nettype none

`include "rob_config.svh"

module arch_map (
    input  wire                                  clock,
    input  wire                                  reset,
    input  retire_pkg::commit_bundle_t           commit,
    input  uop_pkg::arn_t                        map_arn,
    output uop_pkg::prn_t                        map_prn,
    output retire_pkg::freed_t [`ROB_N-1:0]      freed_prn
);

    import uop_pkg::*;

    prn_t map_q [2**`ARN_W];

    logic [`ROB_N-1:0] lane_wr;

    genvar g;
    generate
        for (g = 0; g < `ROB_N; g++) begin : g_wr
            // arn 0 is hardwired, never remapped
            assign lane_wr[g] = commit[g].valid && commit[g].entry.has_dest &&
                                commit[g].entry.dest_arn != '0;
        end
    endgenerate

    assign map_prn = map_q[map_arn];

    // each lane reports the mapping it replaces before the edge
    always_comb begin
        for (int i = 0; i < `ROB_N; i++) begin
            freed_prn[i] = '0;
            if (lane_wr[i]) begin
                freed_prn[i].valid = 1'b1;
                freed_prn[i].prn   = map_q[commit[i].entry.dest_arn];
                // an older lane renamed the same arn this cycle
                for (int j = 0; j < i; j++) begin
                    if (lane_wr[j] && commit[j].entry.dest_arn == commit[i].entry.dest_arn) begin
                        freed_prn[i].prn = commit[j].entry.dest_prn;
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int a = 0; a < 2**`ARN_W; a++) begin
                map_q[a] <= prn_t'(a);   // identity
            end
        end else begin
            for (int i = 0; i < `ROB_N; i++) begin
                if (lane_wr[i]) begin
                    map_q[commit[i].entry.dest_arn] <= commit[i].entry.dest_prn;  // later lane wins
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/rob_regs.sv */
`default_nettype none

`include "rob_config.svh"

module rob_regs (
    input  wire                          clock,
    input  wire                          reset,
    input  retire_pkg::cfg_req_t         cfg,
    input  retire_pkg::commit_bundle_t   commit,
    input  wire                          squash,
    output logic [`ROB_PTR_W-1:0]        alert_depth,
    output logic [7:0]                   cfg_rdata
);

    import retire_pkg::*;

    logic [7:0] retired_cnt;
    logic [7:0] squash_cnt;
    logic [7:0] n_retired;
    logic       depth_ok;

    always_comb begin
        n_retired = '0;
        for (int i = 0; i < `ROB_N; i++) begin
            n_retired = n_retired + {7'd0, commit[i].valid};
        end
    end

    // thresholds of zero or of ROB_SZ and up are ignored
    assign depth_ok = cfg.wdata != 8'd0 && cfg.wdata < 8'(`ROB_SZ);

    always_ff @(posedge clock) begin
        if (reset) begin
            alert_depth <= `ROB_PTR_W'(`ROB_N);
            retired_cnt <= '0;
            squash_cnt  <= '0;
        end else begin
            if (cfg.write && cfg.addr == REG_ALERT && depth_ok) begin
                alert_depth <= cfg.wdata[`ROB_PTR_W-1:0];
            end
            retired_cnt <= retired_cnt + n_retired;       // wraps at 256
            squash_cnt  <= squash_cnt + {7'd0, squash};
        end
    end

    always_comb begin
        case (cfg.addr)
            REG_ALERT:    cfg_rdata = {{(8 - `ROB_PTR_W){1'b0}}, alert_depth};
            REG_RETIRED:  cfg_rdata = retired_cnt;
            REG_SQUASHES: cfg_rdata = squash_cnt;
            default:      cfg_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/rob_subsystem.sv */
`default_nettype none

`include "rob_config.svh"

module rob_subsystem (
    input  wire                                  clock,
    input  wire                                  reset,
    input  uop_pkg::dispatch_t                   dispatch,
    input  retire_pkg::fu_result_t [`FU_CNT-1:0] fu_results,
    input  retire_pkg::cfg_req_t                 cfg,
    input  uop_pkg::arn_t                        map_arn,
    output retire_pkg::commit_bundle_t           commit,
    output logic                                 squash,
    output logic                                 almost_full,
    output uop_pkg::robn_t [`ROB_N-1:0]          tail_robns,
    output logic [7:0]                           cfg_rdata,
    output retire_pkg::freed_t [`ROB_N-1:0]      freed_prn,
    output uop_pkg::prn_t                        map_prn
);

    logic [`ROB_PTR_W-1:0] alert_depth;

    rob i_rob (
        .clock       (clock),
        .reset       (reset),
        .alert_depth (alert_depth),
        .dispatch    (dispatch),
        .fu_results  (fu_results),
        .commit      (commit),
        .squash      (squash),
        .almost_full (almost_full),
        .tail_robns  (tail_robns)
    );

    rob_regs i_rob_regs (
        .clock       (clock),
        .reset       (reset),
        .cfg         (cfg),
        .commit      (commit),
        .squash      (squash),
        .alert_depth (alert_depth),
        .cfg_rdata   (cfg_rdata)
    );

    arch_map i_arch_map (
        .clock     (clock),
        .reset     (reset),
        .commit    (commit),
        .map_arn   (map_arn),
        .map_prn   (map_prn),
        .freed_prn (freed_prn)
    );

endmodule

`default_nettype wire

/* dv/clock_gen.sv */
`default_nettype none

module clock_gen (
    output logic clock,
    output logic reset
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;    // 40 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

/* dv/rob_props.sv */
`default_nettype none

`include "rob_config.svh"

module rob_props (
    input wire                        clock,
    input wire                        reset,
    input wire [`ROB_CNT_W-1:0]       count,
    input wire                        squash,
    input retire_pkg::commit_bundle_t commit
);

    timeunit 1ns;
    timeprecision 1ps;

    occupancy_bound: assert property (
        @(posedge clock) disable iff (reset) count <= `ROB_CNT_W'(`ROB_SZ)
    ) else $error("reorder buffer occupancy above its depth");

    // a mispredict leaves nothing behind
    squash_empties: assert property (
        @(posedge clock) disable iff (reset) squash |=> count == '0
    ) else $error("reorder buffer not empty after squash");

    commit_in_order: assert property (
        @(posedge clock) disable iff (reset) commit[1].valid |-> commit[0].valid
    ) else $error("commit lane 1 valid without lane 0");

endmodule

bind rob rob_props i_rob_props (
    .clock  (clock),
    .reset  (reset),
    .count  (count),
    .squash (squash),
    .commit (commit)
);

`default_nettype wire

/* dv/rob_tb.sv */
`default_nettype none

`include "rob_config.svh"

module rob_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import uop_pkg::*;
    import retire_pkg::*;

    localparam logic [3:0] NC = 4'hf;       // no completion on that port
    localparam int N_ROWS = 26;

    // lane kind 0 is an alu op, 1 a well predicted branch, 2 a mispredicted one
    typedef struct packed {
        logic [1:0]       dv;
        logic [1:0][1:0]  kind;
        logic [2:0][3:0]  comp;             // age among pending entries
        logic             wr;
        logic [1:0]       addr;
        logic [7:0]       wdata;
    } row_t;

    logic clock;
    logic reset;
    dispatch_t dispatch;
    fu_result_t [`FU_CNT-1:0] fu_results;
    cfg_req_t cfg;
    arn_t map_arn;
    commit_bundle_t commit;
    logic squash;
    logic almost_full;
    robn_t [`ROB_N-1:0] tail_robns;
    logic [7:0] cfg_rdata;
    freed_t [`ROB_N-1:0] freed_prn;
    prn_t map_prn;

    // reference model
    rob_entry_t m_ent [`ROB_SZ];
    logic       m_bad [`ROB_SZ];
    robn_t      order_q [$];
    robn_t      m_tail;
    prn_t       m_map [2**`ARN_W];
    logic [3:0] m_alert;
    logic [7:0] m_retired;
    logic [7:0] m_squashes;

    row_t rows [N_ROWS];
    int   cnt;

    clock_gen i_clock_gen (.clock(clock), .reset(reset));

    rob_subsystem i_rob_subsystem (
        .clock(clock), .reset(reset), .dispatch(dispatch), .fu_results(fu_results),
        .cfg(cfg), .map_arn(map_arn), .commit(commit), .squash(squash),
        .almost_full(almost_full), .tail_robns(tail_robns), .cfg_rdata(cfg_rdata),
        .freed_prn(freed_prn), .map_prn(map_prn)
    );

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_commit(input string name, input commit_bundle_t exp,
                                input commit_bundle_t act);
        if (exp !== act)
            stop_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act)
            stop_run($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act)
            stop_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_robn(input string name, input robn_t exp, input robn_t act);
        if (exp !== act)
            stop_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_prn(input string name, input prn_t exp, input prn_t act);
        if (exp !== act)
            stop_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_freed(input string name, input freed_t exp, input freed_t act);
        if (exp !== act)
            stop_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
    endtask

    function automatic row_t make_row(input logic [1:0] dv, input logic [1:0] k0,
                                      input logic [1:0] k1, input logic [3:0] c0,
                                      input logic [3:0] c1, input logic [3:0] c2,
                                      input logic wr, input logic [1:0] addr,
                                      input logic [7:0] wdata);
        row_t r;
        r.dv      = dv;
        r.kind[0] = k0;
        r.kind[1] = k1;
        r.comp[0] = c0;
        r.comp[1] = c1;
        r.comp[2] = c2;
        r.wr      = wr;
        r.addr    = addr;
        r.wdata   = wdata;
        return r;
    endfunction

    function automatic rob_entry_t random_entry(input logic [1:0] kind);
        rob_entry_t e;
        e.executed       = 1'($urandom);     // the buffer must clear these
        e.success        = 1'($urandom);
        e.is_store       = 1'b0;
        e.cond_branch    = kind != 2'd0;
        e.uncond_branch  = 1'b0;
        e.predict_taken  = 1'b1;
        e.predict_target = $urandom;
        e.resolve_taken  = 1'($urandom);
        e.resolve_target = $urandom;
        e.has_dest       = 1'($urandom);
        e.dest_arn       = arn_t'($urandom);
        e.dest_prn       = prn_t'($urandom);
        e.pc             = $urandom;
        return e;
    endfunction

    function automatic logic [7:0] reg_value(input logic [1:0] addr);
        case (addr)
            REG_ALERT:    return {4'd0, m_alert};
            REG_RETIRED:  return m_retired;
            REG_SQUASHES: return m_squashes;
            default:      return 8'd0;
        endcase
    endfunction

    // drive after the edge, check mid cycle, then advance the model by one edge
    task automatic apply_row(input row_t r);
        rob_entry_t     fresh [`ROB_N];
        commit_bundle_t exp_c;
        freed_t         exp_f;
        prn_t           tmp_map [2**`ARN_W];
        robn_t          pend [$];
        robn_t          rn;
        logic           exp_sq;
        logic           exp_af;
        logic           stop;
        @(posedge clock);
        #2;
        foreach (order_q[i]) begin
            if (!m_ent[order_q[i]].executed) begin
                pend.push_back(order_q[i]);
            end
        end
        for (int i = 0; i < `ROB_N; i++) begin
            fresh[i]             = random_entry(r.kind[i]);
            dispatch.valid[i]    = r.dv[i];
            dispatch.entry[i]    = fresh[i];
        end
        fu_results = '0;
        for (int f = 0; f < `FU_CNT; f++) begin
            if (r.comp[f] != NC && int'(r.comp[f]) < pend.size()) begin
                rn = pend[r.comp[f]];
                fu_results[f].valid        = 1'b1;
                fu_results[f].robn         = rn;
                fu_results[f].branch_taken = m_ent[rn].cond_branch ? 1'b1 : 1'($urandom);
                fu_results[f].target_addr  = !m_ent[rn].cond_branch ? $urandom :
                    (m_bad[rn] ? m_ent[rn].predict_target ^ 32'h4 : m_ent[rn].predict_target);
            end
        end
        cfg.write  = r.wr;
        cfg.addr   = r.addr;
        cfg.wdata  = r.wdata;
        map_arn    = arn_t'($urandom);
        #18;
        exp_c  = '0;
        exp_sq = 1'b0;
        stop   = 1'b0;
        for (int i = 0; i < `ROB_N; i++) begin
            if (!stop && i < order_q.size() && m_ent[order_q[i]].executed) begin
                exp_c[i].valid = 1'b1;
                exp_c[i].entry = m_ent[order_q[i]];
                if (!m_ent[order_q[i]].success) begin
                    exp_sq = 1'b1;
                    stop   = 1'b1;
                end
            end else begin
                stop = 1'b1;
            end
        end
        exp_af = order_q.size() > `ROB_SZ - int'(m_alert);
        check_commit("commit", exp_c, commit);
        check_bit("squash", exp_sq, squash);
        check_bit("almost_full", exp_af, almost_full);
        check_robn("tail lane 0", m_tail, tail_robns[0]);
        check_robn("tail lane 1", m_tail + 4'd1, tail_robns[1]);
        check_prn("map_prn", m_map[map_arn], map_prn);
        check_byte("cfg_rdata", reg_value(r.addr), cfg_rdata);
        tmp_map = m_map;
        for (int i = 0; i < `ROB_N; i++) begin
            exp_f = '0;
            if (exp_c[i].valid && exp_c[i].entry.has_dest && exp_c[i].entry.dest_arn != '0) begin
                exp_f.valid = 1'b1;
                exp_f.prn   = tmp_map[exp_c[i].entry.dest_arn];
                tmp_map[exp_c[i].entry.dest_arn] = exp_c[i].entry.dest_prn;
            end
            check_freed($sformatf("freed_prn lane %0d", i), exp_f, freed_prn[i]);
        end
        // the edge
        m_map = tmp_map;
        for (int i = 0; i < `ROB_N; i++) begin
            if (exp_c[i].valid) begin
                void'(order_q.pop_front());
                m_retired = m_retired + 8'd1;
            end
        end
        if (exp_sq) begin
            order_q.delete();
            m_tail     = '0;
            m_squashes = m_squashes + 8'd1;
        end else if (!exp_af) begin
            for (int i = 0; i < `ROB_N; i++) begin
                if (r.dv[i]) begin
                    m_ent[m_tail]                = fresh[i];
                    m_ent[m_tail].executed       = 1'b0;
                    m_ent[m_tail].success        = 1'b1;
                    m_ent[m_tail].resolve_taken  = 1'b0;
                    m_ent[m_tail].resolve_target = '0;
                    m_bad[m_tail]                = r.kind[i] == 2'd2;
                    order_q.push_back(m_tail);
                    m_tail = m_tail + 4'd1;
                end
            end
        end
        for (int f = 0; f < `FU_CNT; f++) begin
            if (fu_results[f].valid) begin
                rn = fu_results[f].robn;
                m_ent[rn].executed       = 1'b1;
                m_ent[rn].resolve_taken  = fu_results[f].branch_taken;
                m_ent[rn].resolve_target = fu_results[f].target_addr;
                m_ent[rn].success = !(m_ent[rn].cond_branch || m_ent[rn].uncond_branch) ||
                    (fu_results[f].branch_taken == m_ent[rn].predict_taken &&
                     fu_results[f].target_addr == m_ent[rn].predict_target);
            end
        end
        if (r.wr && r.addr == REG_ALERT && r.wdata != 8'd0 && r.wdata < 8'd16) begin
            m_alert = r.wdata[3:0];
        end
    endtask

    initial begin
        #(40 * 3000);
        stop_run("timeout: simulation did not finish in time");
    end

    initial begin
        void'($urandom(32'h932a));
        dispatch   = '0;
        fu_results = '0;
        cfg        = '0;
        map_arn    = '0;
        for (int a = 0; a < 2**`ARN_W; a++) m_map[a] = prn_t'(a);
        m_tail     = '0;
        m_alert    = 4'd2;
        m_retired  = '0;
        m_squashes = '0;

        // in-order retirement with out-of-order completion
        rows[0]  = make_row(2'b11, 0, 1, NC, NC, NC, 0, 0, 0);
        rows[1]  = make_row(2'b11, 0, 0, NC, 1, NC, 0, 1, 0);
        rows[2]  = make_row(2'b00, 0, 0, 0, NC, NC, 0, 1, 0);
        rows[3]  = make_row(2'b00, 0, 0, 0, NC, NC, 0, 2, 0);
        rows[4]  = make_row(2'b00, 0, 0, NC, NC, NC, 0, 0, 0);
        // mispredicted branch with younger entries already done
        rows[5]  = make_row(2'b11, 0, 2, NC, NC, NC, 0, 0, 0);
        rows[6]  = make_row(2'b11, 0, 0, NC, NC, NC, 0, 0, 0);
        rows[7]  = make_row(2'b00, 0, 0, 3, 2, NC, 0, 2, 0);
        rows[8]  = make_row(2'b00, 0, 0, 1, NC, NC, 0, 2, 0);
        rows[9]  = make_row(2'b00, 0, 0, 0, NC, NC, 0, 2, 0);
        rows[10] = make_row(2'b11, 1, 0, NC, NC, NC, 0, 2, 0);
        rows[11] = make_row(2'b00, 0, 0, NC, NC, NC, 0, 2, 0);
        rows[12] = make_row(2'b11, 1, 0, NC, NC, NC, 0, 1, 0);
        rows[13] = make_row(2'b00, 0, 0, 1, 0, NC, 0, 1, 0);
        rows[14] = make_row(2'b00, 0, 0, NC, NC, NC, 0, 1, 0);
        // back-pressure at threshold 4
        rows[15] = make_row(2'b00, 0, 0, NC, NC, NC, 1, 0, 8'd4);
        for (int i = 16; i < 23; i++) rows[i] = make_row(2'b11, 0, 1, NC, NC, NC, 0, 0, 0);
        rows[23] = make_row(2'b11, 0, 0, NC, NC, NC, 0, 0, 0);
        rows[24] = make_row(2'b11, 0, 0, NC, NC, NC, 1, 0, 8'd0);
        rows[25] = make_row(2'b01, 0, 0, NC, NC, NC, 0, 0, 0);

        cnt = 0;
        do begin
            @(posedge clock);
            cnt++;
            if (cnt > 20) stop_run("timeout: reset never released");
        end while (reset);

        for (int i = 0; i < N_ROWS; i++) apply_row(rows[i]);

        cnt = 0;
        while (order_q.size() > 0) begin
            apply_row(make_row(2'b00, 0, 0, 0, 1, 2, 0, 1, 0));
            cnt++;
            if (cnt > 40) stop_run("timeout: reorder buffer did not drain");
        end
        apply_row(make_row(2'b00, 0, 0, NC, NC, NC, 0, 1, 0));
        apply_row(make_row(2'b00, 0, 0, NC, NC, NC, 0, 2, 0));
        apply_row(make_row(2'b00, 0, 0, NC, NC, NC, 0, 0, 0));

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

/* rob/rob.sv */
`default_nettype none

`include "rob_config.svh"

module rob (
    input  wire                                      clock,
    input  wire                                      reset,
    input  wire  [`ROB_PTR_W-1:0]                    alert_depth,
    input  uop_pkg::dispatch_t                       dispatch,
    input  retire_pkg::fu_result_t [`FU_CNT-1:0]     fu_results,
    output retire_pkg::commit_bundle_t               commit,
    output logic                                     squash,
    output logic                                     almost_full,
    output uop_pkg::robn_t [`ROB_N-1:0]              tail_robns
);

    import uop_pkg::*;
    import retire_pkg::*;

    localparam logic [`ROB_CNT_W-1:0] DEPTH = `ROB_SZ;

    rob_entry_t entries [`ROB_SZ];

    robn_t                 head;
    robn_t                 tail;
    logic [`ROB_CNT_W-1:0] count;

    robn_t [`ROB_N-1:0]      lane_idx;   // head-relative commit slots
    robn_t [`ROB_N-1:0]      slot;       // where each dispatch lane lands
    rob_entry_t [`ROB_N-1:0] fresh;
    logic [`ROB_CNT_W-1:0]   n_commit;
    logic [`ROB_CNT_W-1:0]   n_accept;
    logic                    accept;
    logic                    blocked;
    logic [`ROB_CNT_W-1:0]   threshold;

    genvar g;
    generate
        for (g = 0; g < `ROB_N; g++) begin : g_lane
            assign lane_idx[g]   = head + robn_t'(g);
            assign tail_robns[g] = tail + robn_t'(g);
        end
    endgenerate

    // occupancy above ROB_SZ - alert_depth holds off dispatch
    assign threshold   = DEPTH - {1'b0, alert_depth};
    assign almost_full = count > threshold;

    // retire in order from head, stop at first unfinished entry
    always_comb begin
        commit   = '0;
        squash   = 1'b0;
        n_commit = '0;
        blocked  = 1'b0;
        for (int i = 0; i < `ROB_N; i++) begin
            if (!blocked && count > i && entries[lane_idx[i]].executed) begin
                commit[i].valid = 1'b1;
                commit[i].entry = entries[lane_idx[i]];
                n_commit        = n_commit + 1'b1;
                if (!entries[lane_idx[i]].success) begin
                    squash  = 1'b1;   // mispredicted branch retires, younger ones go
                    blocked = 1'b1;
                end
            end else begin
                blocked = 1'b1;
            end
        end
    end

    assign accept = !almost_full && !squash;

    // valid lanes pack into consecutive slots from tail
    always_comb begin
        n_accept = '0;
        for (int i = 0; i < `ROB_N; i++) begin
            slot[i]                 = tail + n_accept[`ROB_PTR_W-1:0];
            fresh[i]                = dispatch.entry[i];
            fresh[i].executed       = 1'b0;
            fresh[i].success        = 1'b1;
            fresh[i].resolve_taken  = 1'b0;
            fresh[i].resolve_target = '0;
            if (accept && dispatch.valid[i]) begin
                n_accept = n_accept + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (squash) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + n_commit[`ROB_PTR_W-1:0];
            tail  <= tail + n_accept[`ROB_PTR_W-1:0];
            count <= count + n_accept - n_commit;
        end
    end

    // dispatch writes the entry payload and completions then mark it done
    always_ff @(posedge clock) begin
        for (int i = 0; i < `ROB_N; i++) begin
            if (accept && dispatch.valid[i]) begin
                entries[slot[i]] <= fresh[i];
            end
        end
        for (int f = 0; f < `FU_CNT; f++) begin
            if (fu_results[f].valid) begin
                entries[fu_results[f].robn].executed       <= 1'b1;
                entries[fu_results[f].robn].resolve_taken  <= fu_results[f].branch_taken;
                entries[fu_results[f].robn].resolve_target <= fu_results[f].target_addr;
                if (entries[fu_results[f].robn].cond_branch ||
                    entries[fu_results[f].robn].uncond_branch) begin
                    entries[fu_results[f].robn].success <=
                        (fu_results[f].branch_taken ==
                         entries[fu_results[f].robn].predict_taken) &&
                        (fu_results[f].target_addr ==
                         entries[fu_results[f].robn].predict_target);
                end else begin
                    entries[fu_results[f].robn].success <= 1'b1;  // nothing to mispredict
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rob_subsystem.f */
+incdir+common
common/uop_pkg.sv
common/retire_pkg.sv
rob/rob.sv
design/rob_regs.sv
design/arch_map.sv
design/rob_subsystem.sv
dv/clock_gen.sv
dv/rob_props.sv
dv/rob_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the reorder buffer testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    -Wno-fatal \
    --top-module rob_tb \
    -f rob_subsystem.f \
    --Mdir obj_dir \
    -o rob_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit $status
fi

./obj_dir/rob_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi

exit 0
